// ==== flist.f ====
+incdir+logic
logic/mem_sys_pkg.sv
logic/sram_bank.sv
logic/bus_arbiter.sv
logic/mem_ctrl.sv
logic/mem_sys_top.sv
verification/mem_sys_tb.sv

// ==== verification/mem_sys_testdata.txt ====
# W addr data strobe | RI/RL addr expected | C ifu_addr lsu_addr ifu_expected lsu_expected
# P addr data strobe expected: LSU write and LSU read of one word pending together
W 00000000 11111111 f
W 00000004 22222222 f
W 00000008 33333333 f
W 0000000c 44444444 f
RI 00000000 11111111
RI 00000004 22222222
RI 00000008 33333333
RI 0000000c 44444444
RL 00000000 11111111
RL 00000004 22222222
RL 00000008 33333333
RL 0000000c 44444444
W 00000010 aabbccdd f
W 00000010 00000011 1
W 00000010 55660000 c
RL 00000010 5566cc11
RI 00000410 5566cc11
RL fffffc10 5566cc11
C 00000004 00000008 22222222 33333333
P 00000014 deadbeef f deadbeef
RI 00000014 deadbeef
W 000003fc 01020304 f
RL 000003fc 01020304
C 000003fc 00000010 01020304 5566cc11

// ==== verification/mem_sys_tb.sv ====
`timescale 1ns/1ps
`include "mem_sys_params.svh"

module mem_sys_tb;

    logic                 clk;
    logic                 rst;
    mem_sys_pkg::rd_req_t ifu_req;
    mem_sys_pkg::rd_rsp_t ifu_rsp;
    mem_sys_pkg::rd_req_t lsu_rd_req;
    mem_sys_pkg::rd_rsp_t lsu_rd_rsp;
    mem_sys_pkg::wr_req_t lsu_wr_req;
    mem_sys_pkg::wr_rsp_t lsu_wr_rsp;

    logic [15:0] lfsr = 16'd16205;
    int          errors = 0;

    mem_sys_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .ifu_req    (ifu_req),
        .ifu_rsp    (ifu_rsp),
        .lsu_rd_req (lsu_rd_req),
        .lsu_rd_rsp (lsu_rd_rsp),
        .lsu_wr_req (lsu_wr_req),
        .lsu_wr_rsp (lsu_wr_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic next_rand_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int rand_delay();
        int d;
        d = next_rand_bit();
        d = 2 * d + next_rand_bit();
        return d;                                    // 0 to 3 cycles
    endfunction

    function automatic mem_sys_pkg::rd_rsp_t rd_rsp_of(input bit is_ifu);
        return is_ifu ? ifu_rsp : lsu_rd_rsp;
    endfunction

    task automatic drive_rd(input bit is_ifu, input mem_sys_pkg::rd_req_t req);
        if (is_ifu) begin
            ifu_req = req;
        end else begin
            lsu_rd_req = req;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("%s handshake never completed at %0t", what, $time);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic wait_rd(input bit is_ifu, input bit want_arready);
        mem_sys_pkg::rd_rsp_t rsp;
        int n;
        string what;
        n = 0;
        if (is_ifu) begin
            what = "IFU";
        end else begin
            what = "LSU";
        end
        if (want_arready) begin
            what = {what, " arready"};
        end else begin
            what = {what, " rvalid"};
        end
        rsp = rd_rsp_of(is_ifu);
        while (want_arready ? !rsp.arready : !rsp.rvalid) begin
            @(negedge clk);
            n++;
            if (n > 200) begin
                report_timeout(what);
            end
            rsp = rd_rsp_of(is_ifu);
        end
    endtask

    // One read at a master port, returns data and the time it completed
    task automatic do_read(input bit is_ifu, input logic [`MEM_ADDR_W-1:0] addr,
                           output logic [`MEM_DATA_W-1:0] data, output time t_done);
        mem_sys_pkg::rd_req_t req;
        mem_sys_pkg::rd_rsp_t rsp;
        int delay;
        req = '0;
        req.arvalid = 1'b1;
        req.araddr = addr;
        drive_rd(is_ifu, req);
        wait_rd(is_ifu, 1'b1);
        @(negedge clk);                              // Address beat taken at this edge
        req.arvalid = 1'b0;
        drive_rd(is_ifu, req);
        wait_rd(is_ifu, 1'b0);
        rsp = rd_rsp_of(is_ifu);
        data = rsp.rdata;
        delay = rand_delay();
        repeat (delay) begin
            @(negedge clk);
            rsp = rd_rsp_of(is_ifu);
            assert (rsp.rvalid && rsp.rdata === data) else begin
                $display("mismatch at %0t: read response not held, rvalid %b data %h was %h",
                         $time, rsp.rvalid, rsp.rdata, data);
                errors++;
            end
        end
        req.rready = 1'b1;
        drive_rd(is_ifu, req);
        @(negedge clk);
        req.rready = 1'b0;
        drive_rd(is_ifu, req);
        t_done = $time;
    endtask

    task automatic do_write(input logic [`MEM_ADDR_W-1:0] addr,
                            input logic [`MEM_DATA_W-1:0] data,
                            input logic [`MEM_STRB_W-1:0] strb, output time t_done);
        int n;
        int delay;
        lsu_wr_req = '0;
        lsu_wr_req.awvalid = 1'b1;
        lsu_wr_req.awaddr = addr;
        lsu_wr_req.wvalid = 1'b1;
        lsu_wr_req.wdata = data;
        lsu_wr_req.wstrb = strb;
        n = 0;
        while (!lsu_wr_rsp.awready) begin
            @(negedge clk);
            n++;
            if (n > 200) begin
                report_timeout("LSU awready");
            end
        end
        assert (lsu_wr_rsp.wready) else begin
            $display("mismatch at %0t: wready low while awready high", $time);
            errors++;
        end
        @(negedge clk);
        lsu_wr_req.awvalid = 1'b0;
        lsu_wr_req.wvalid = 1'b0;
        n = 0;
        while (!lsu_wr_rsp.bvalid) begin
            @(negedge clk);
            n++;
            if (n > 200) begin
                report_timeout("LSU bvalid");
            end
        end
        delay = rand_delay();
        repeat (delay) begin
            @(negedge clk);
            assert (lsu_wr_rsp.bvalid) else begin
                $display("mismatch at %0t: bvalid dropped before bready", $time);
                errors++;
            end
        end
        lsu_wr_req.bready = 1'b1;
        @(negedge clk);
        lsu_wr_req.bready = 1'b0;
        t_done = $time;
    endtask

    task automatic check_word(input string who, input logic [`MEM_DATA_W-1:0] got,
                              input logic [`MEM_DATA_W-1:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s read expected %h observed %h", $time, who, exp, got);
            errors++;
        end
    endtask

    task automatic check_order(input string what, input time first, input time second);
        assert (first < second) else begin
            $display("mismatch at %0t: %s completed out of order (%0t, %0t)",
                     $time, what, first, second);
            errors++;
        end
    endtask

    initial begin
        int fd;
        int n_test;
        int n_pass;
        int n_fail;
        int err_before;
        string line;
        string op;
        logic [31:0] f1, f2, f3, f4;
        logic [31:0] d1, d2;
        time t1, t2;

        ifu_req = '0;
        lsu_rd_req = '0;
        lsu_wr_req = '0;
        rst = 1'b1;
        n_test = 0;
        n_pass = 0;
        n_fail = 0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        err_before = errors;
        assert (!ifu_rsp.arready && !ifu_rsp.rvalid && !lsu_rd_rsp.arready &&
                !lsu_rd_rsp.rvalid && !lsu_wr_rsp.awready && !lsu_wr_rsp.wready &&
                !lsu_wr_rsp.bvalid) else begin
            $display("mismatch at %0t: ready or valid output high after reset", $time);
            errors++;
        end
        n_test++;
        if (errors == err_before) begin
            n_pass++;
        end else begin
            n_fail++;
        end
        $display("test %0d reset: %s", n_test, errors == err_before ? "pass" : "FAIL");

        fd = $fopen("verification/mem_sys_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            errors++;
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() < 2 || line[0] == "#") continue;
                void'($sscanf(line, "%s %h %h %h %h", op, f1, f2, f3, f4));
                err_before = errors;
                case (op)
                    "W":  do_write(f1, f2, f3[`MEM_STRB_W-1:0], t1);
                    "RI": begin
                        do_read(1'b1, f1, d1, t1);
                        check_word("IFU", d1, f2);
                    end
                    "RL": begin
                        do_read(1'b0, f1, d1, t1);
                        check_word("LSU", d1, f2);
                    end
                    "C": begin
                        fork
                            do_read(1'b1, f1, d1, t1);
                            do_read(1'b0, f2, d2, t2);
                        join
                        check_word("IFU", d1, f3);
                        check_word("LSU", d2, f4);
                        check_order("IFU read before LSU read", t1, t2);
                    end
                    "P": begin
                        fork
                            do_write(f1, f2, f3[`MEM_STRB_W-1:0], t1);
                            do_read(1'b0, f1, d2, t2);
                        join
                        check_word("LSU", d2, f4);
                        check_order("LSU write before LSU read", t1, t2);
                    end
                    default: begin
                        $display("unknown operation %s in the test data", op);
                        errors++;
                    end
                endcase
                repeat (2) @(negedge clk);           // Idle gap between tests
                n_test++;
                if (errors == err_before) begin
                    n_pass++;
                end else begin
                    n_fail++;
                end
                $display("test %0d %s %h: %s", n_test, op, f1,
                         errors == err_before ? "pass" : "FAIL");
            end
            $fclose(fd);
        end

        $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== logic/mem_sys_top.sv ====
`timescale 1ns/1ps
`include "mem_sys_params.svh"

module mem_sys_top (
    input  logic                 clk,
    input  logic                 rst,
    input  mem_sys_pkg::rd_req_t ifu_req,
    output mem_sys_pkg::rd_rsp_t ifu_rsp,
    input  mem_sys_pkg::rd_req_t lsu_rd_req,
    output mem_sys_pkg::rd_rsp_t lsu_rd_rsp,
    input  mem_sys_pkg::wr_req_t lsu_wr_req,
    output mem_sys_pkg::wr_rsp_t lsu_wr_rsp
);

    mem_sys_pkg::rd_req_t mem_rd_req;
    mem_sys_pkg::rd_rsp_t mem_rd_rsp;
    mem_sys_pkg::wr_req_t mem_wr_req;
    mem_sys_pkg::wr_rsp_t mem_wr_rsp;

    logic [`MEM_BANKS-1:0]                  bank_en;
    logic [`MEM_BANKS-1:0][`MEM_STRB_W-1:0] bank_we;
    logic [$clog2(`MEM_ROWS)-1:0]           bank_row;     // Shared by all banks
    logic [`MEM_DATA_W-1:0]                 bank_wdata;
    logic [`MEM_BANKS-1:0][`MEM_DATA_W-1:0] bank_rdata;

    bus_arbiter arbiter_i (
        .clk        (clk),
        .rst        (rst),
        .ifu_req    (ifu_req),
        .ifu_rsp    (ifu_rsp),
        .lsu_rd_req (lsu_rd_req),
        .lsu_rd_rsp (lsu_rd_rsp),
        .lsu_wr_req (lsu_wr_req),
        .lsu_wr_rsp (lsu_wr_rsp),
        .mem_rd_req (mem_rd_req),
        .mem_rd_rsp (mem_rd_rsp),
        .mem_wr_req (mem_wr_req),
        .mem_wr_rsp (mem_wr_rsp)
    );

    mem_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .rd_req     (mem_rd_req),
        .rd_rsp     (mem_rd_rsp),
        .wr_req     (mem_wr_req),
        .wr_rsp     (mem_wr_rsp),
        .bank_en    (bank_en),
        .bank_we    (bank_we),
        .bank_row   (bank_row),
        .bank_wdata (bank_wdata),
        .bank_rdata (bank_rdata)
    );

    // Word-interleaved banks
    for (genvar b = 0; b < `MEM_BANKS; b++) begin : g_bank
        sram_bank bank_i (
            .clk   (clk),
            .en    (bank_en[b]),
            .we    (bank_we[b]),
            .row   (bank_row),
            .wdata (bank_wdata),
            .rdata (bank_rdata[b])
        );
    end

endmodule

// ==== logic/mem_ctrl.sv ====
`timescale 1ns/1ps
`include "mem_sys_params.svh"

module mem_ctrl (
    input  logic                                   clk,
    input  logic                                   rst,
    input  mem_sys_pkg::rd_req_t                   rd_req,
    output mem_sys_pkg::rd_rsp_t                   rd_rsp,
    input  mem_sys_pkg::wr_req_t                   wr_req,
    output mem_sys_pkg::wr_rsp_t                   wr_rsp,
    output logic [`MEM_BANKS-1:0]                  bank_en,
    output logic [`MEM_BANKS-1:0][`MEM_STRB_W-1:0] bank_we,
    output logic [$clog2(`MEM_ROWS)-1:0]           bank_row,
    output logic [`MEM_DATA_W-1:0]                 bank_wdata,
    input  logic [`MEM_BANKS-1:0][`MEM_DATA_W-1:0] bank_rdata
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_RD_WAIT = 2'd1;
    localparam logic [1:0] ST_RD_RESP = 2'd2;
    localparam logic [1:0] ST_WR_RESP = 2'd3;

    logic [1:0]                    state;
    logic [$clog2(`MEM_BANKS)-1:0] rd_bank;    // Bank holding the pending read word
    logic [`MEM_DATA_W-1:0]        rdata_q;
    logic                          rd_go;
    logic                          wr_go;
    mem_sys_pkg::mem_addr_u        rd_addr;
    mem_sys_pkg::mem_addr_u        wr_addr;
    mem_sys_pkg::mem_addr_u        sel_addr;

    assign rd_addr.raw = rd_req.araddr;
    assign wr_addr.raw = wr_req.awaddr;

    // Reads win when both channels ask at once
    assign rd_go = (state == ST_IDLE) && rd_req.arvalid;
    assign wr_go = (state == ST_IDLE) && !rd_req.arvalid && wr_req.awvalid && wr_req.wvalid;

    assign sel_addr   = rd_go ? rd_addr : wr_addr;
    assign bank_row   = sel_addr.field.row;
    assign bank_wdata = wr_req.wdata;

    always_comb begin
        for (int b = 0; b < `MEM_BANKS; b++) begin
            bank_en[b] = (rd_go || wr_go) && (sel_addr.field.bank == b);
            bank_we[b] = (wr_go && (sel_addr.field.bank == b)) ? wr_req.wstrb : '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (rd_go) begin
                        state <= ST_RD_WAIT;             // Bank reads on this edge
                    end else if (wr_go) begin
                        state <= ST_WR_RESP;             // Bank writes on this edge
                    end
                end
                ST_RD_WAIT: begin
                    state <= ST_RD_RESP;
                end
                ST_RD_RESP: begin
                    if (rd_req.rready) begin
                        state <= ST_IDLE;
                    end
                end
                ST_WR_RESP: begin
                    if (wr_req.bready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            rd_bank <= rd_addr.field.bank;
        end
        if (state == ST_RD_WAIT) begin
            rdata_q <= bank_rdata[rd_bank];              // Held through back-pressure
        end
    end

    assign rd_rsp.arready = rd_go;                       // One-cycle accept pulse
    assign rd_rsp.rvalid  = (state == ST_RD_RESP);
    assign rd_rsp.rdata   = rdata_q;

    assign wr_rsp.awready = wr_go;
    assign wr_rsp.wready  = wr_go;
    assign wr_rsp.bvalid  = (state == ST_WR_RESP);

endmodule

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/1ps
`include "mem_sys_params.svh"

module bus_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  mem_sys_pkg::rd_req_t ifu_req,
    output mem_sys_pkg::rd_rsp_t ifu_rsp,
    input  mem_sys_pkg::rd_req_t lsu_rd_req,
    output mem_sys_pkg::rd_rsp_t lsu_rd_rsp,
    input  mem_sys_pkg::wr_req_t lsu_wr_req,
    output mem_sys_pkg::wr_rsp_t lsu_wr_rsp,
    output mem_sys_pkg::rd_req_t mem_rd_req,
    input  mem_sys_pkg::rd_rsp_t mem_rd_rsp,
    output mem_sys_pkg::wr_req_t mem_wr_req,
    input  mem_sys_pkg::wr_rsp_t mem_wr_rsp
);

    localparam logic [1:0] ARB_IDLE   = 2'd0;
    localparam logic [1:0] ARB_IFU_RD = 2'd1;
    localparam logic [1:0] ARB_LSU_WR = 2'd2;
    localparam logic [1:0] ARB_LSU_RD = 2'd3;

    logic [1:0]           state;
    logic                 addr_done;   // Slave took the address this grant
    mem_sys_pkg::rd_req_t rd_src;      // Read request of the granted master

    assign rd_src = (state == ARB_IFU_RD) ? ifu_req : lsu_rd_req;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ARB_IDLE;
            addr_done  <= 1'b0;
            ifu_rsp    <= '0;
            lsu_rd_rsp <= '0;
            lsu_wr_rsp <= '0;
            mem_rd_req <= '0;
            mem_wr_req <= '0;
        end else begin
            // Every port falls back to zero unless the grant drives it
            ifu_rsp    <= '0;
            lsu_rd_rsp <= '0;
            lsu_wr_rsp <= '0;
            mem_rd_req <= '0;
            mem_wr_req <= '0;

            case (state)
                ARB_IDLE: begin
                    addr_done <= 1'b0;
                    if (ifu_req.arvalid) begin
                        state <= ARB_IFU_RD;             // Fetch has top priority
                    end else if (lsu_wr_req.awvalid) begin
                        state <= ARB_LSU_WR;
                    end else if (lsu_rd_req.arvalid) begin
                        state <= ARB_LSU_RD;
                    end
                end

                ARB_IFU_RD, ARB_LSU_RD: begin
                    if (mem_rd_rsp.arready) begin
                        addr_done <= 1'b1;
                    end
                    // The master still sees valid high until arready gets back to it,
                    // so the forwarded copy is cut as soon as the slave has taken it
                    mem_rd_req.arvalid <= rd_src.arvalid && !addr_done && !mem_rd_rsp.arready;
                    mem_rd_req.araddr  <= rd_src.araddr;
                    mem_rd_req.rready  <= rd_src.rready;
                    if (state == ARB_IFU_RD) begin
                        ifu_rsp <= mem_rd_rsp;
                    end else begin
                        lsu_rd_rsp <= mem_rd_rsp;
                    end
                    if (mem_rd_rsp.rvalid && rd_src.rready) begin
                        state <= ARB_IDLE;               // Response handshake seen
                    end
                end

                ARB_LSU_WR: begin
                    if (mem_wr_rsp.awready) begin
                        addr_done <= 1'b1;
                    end
                    mem_wr_req.awvalid <= lsu_wr_req.awvalid && !addr_done &&
                                          !mem_wr_rsp.awready;
                    mem_wr_req.awaddr  <= lsu_wr_req.awaddr;
                    mem_wr_req.wvalid  <= lsu_wr_req.wvalid && !addr_done &&
                                          !mem_wr_rsp.awready;
                    mem_wr_req.wdata   <= lsu_wr_req.wdata;
                    mem_wr_req.wstrb   <= lsu_wr_req.wstrb;
                    mem_wr_req.bready  <= lsu_wr_req.bready;
                    lsu_wr_rsp         <= mem_wr_rsp;
                    if (mem_wr_rsp.bvalid && lsu_wr_req.bready) begin
                        state <= ARB_IDLE;
                    end
                end

                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== logic/sram_bank.sv ====
`timescale 1ns/1ps
`include "mem_sys_params.svh"

module sram_bank (
    input  logic                         clk,
    input  logic                         en,
    input  logic [`MEM_STRB_W-1:0]       we,
    input  logic [$clog2(`MEM_ROWS)-1:0] row,
    input  logic [`MEM_DATA_W-1:0]       wdata,
    output logic [`MEM_DATA_W-1:0]       rdata
);

    logic [`MEM_DATA_W-1:0] mem [`MEM_ROWS];   // Contents undefined until written

    always_ff @(posedge clk) begin
        if (en) begin
            if (we == '0) begin
                rdata <= mem[row];                 // Read only on write-free access
            end
            for (int i = 0; i < `MEM_STRB_W; i++) begin
                if (we[i]) begin
                    mem[row][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

// ==== logic/mem_sys_pkg.sv ====
`include "mem_sys_params.svh"

package mem_sys_pkg;

    // Read channel, master to slave
    typedef struct packed {
        logic                   arvalid;
        logic [`MEM_ADDR_W-1:0] araddr;
        logic                   rready;
    } rd_req_t;

    // Read channel, slave to master
    typedef struct packed {
        logic                   arready;
        logic                   rvalid;
        logic [`MEM_DATA_W-1:0] rdata;
    } rd_rsp_t;

    // Write channel, master to slave
    typedef struct packed {
        logic                   awvalid;
        logic [`MEM_ADDR_W-1:0] awaddr;
        logic                   wvalid;
        logic [`MEM_DATA_W-1:0] wdata;
        logic [`MEM_STRB_W-1:0] wstrb;
        logic                   bready;
    } wr_req_t;

    // Write channel, slave to master
    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
    } wr_rsp_t;

    // One address word, seen raw or split for the interleaved banks
    typedef union packed {
        logic [`MEM_ADDR_W-1:0] raw;
        struct packed {
            logic [`MEM_ADDR_W-$clog2(`MEM_ROWS)-$clog2(`MEM_BANKS)-3:0] upper; // Wraps
            logic [$clog2(`MEM_ROWS)-1:0]                                  row;
            logic [$clog2(`MEM_BANKS)-1:0]                                 bank;
            logic [1:0]                                                    offset;
        } field;
    } mem_addr_u;

endpackage

// ==== logic/mem_sys_params.svh ====
`ifndef MEM_SYS_PARAMS_SVH
`define MEM_SYS_PARAMS_SVH

// Memory system sizing

`define MEM_ADDR_W 32   // Byte address width
`define MEM_DATA_W 32   // Bus and bank word width
`define MEM_STRB_W 4    // One strobe per data byte

// Word-interleaved layout of the on-chip memory
`define MEM_BANKS 4     // Banks selected by address bits 3:2
`define MEM_ROWS 64     // Words held in each bank

`endif
